// File: compile.f
+incdir+test
design/core_pkg.sv
design/link_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/step_core.sv
design/debug_unit.sv
design/debug_top.sv
test/tb_debug_top.sv

// File: design/core_pkg.sv
package core_pkg;

	// Opcodes of the accumulator machine
	typedef enum logic [1:0]
	{
		LDI,
		ADDI,
		XORI,
		HALT
	} core_op_e;

	// One ROM word, opcode above operand
	typedef struct packed
	{
		core_op_e   op;
		logic [7:0] operand;
	} core_instr_t;

	// Core state as seen by the debug unit
	typedef struct packed
	{
		logic [7:0]  pc;
		logic [7:0]  acc;
		// Pads the instruction out to two bytes
		logic [5:0]  instr_pad;
		core_instr_t instr;
		logic [15:0] step_count;
		// Only bit 0 carries the flag
		logic [7:0]  halted;
	} core_snap_t;

	localparam int PROG_LEN = 5;

	// Fixed program, ends on HALT
	localparam core_instr_t PROG_ROM [PROG_LEN] = '{
		'{LDI,  8'h05},
		'{ADDI, 8'h03},
		'{XORI, 8'h0F},
		'{ADDI, 8'h21},
		'{HALT, 8'h00}
	};

endpackage

// File: design/debug_top.sv
`timescale 1ns/100ps

module debug_top
(
	input  logic clk,
	input  logic rst,
	input  logic rx,
	output logic tx
);

	import core_pkg::*;

	// Receiver to debug unit
	logic       rx_rdy;
	logic [7:0] rx_byte;

	// Debug unit to transmitter
	logic       tx_write;
	logic [7:0] tx_byte;
	logic       tx_done;

	// Debug unit to core
	logic       step_en;
	core_snap_t snap;

	uart_rx rx0
	(
		.clk     (clk),
		.rst     (rst),
		.rx      (rx),
		.rx_byte (rx_byte),
		.rx_rdy  (rx_rdy)
	);

	uart_tx tx0
	(
		.clk      (clk),
		.rst      (rst),
		.tx_write (tx_write),
		.tx_byte  (tx_byte),
		.tx       (tx),
		.tx_done  (tx_done)
	);

	debug_unit dbg0
	(
		.clk      (clk),
		.rst      (rst),
		.rx_rdy   (rx_rdy),
		.rx_byte  (rx_byte),
		.tx_done  (tx_done),
		.snap     (snap),
		.step_en  (step_en),
		.tx_write (tx_write),
		.tx_byte  (tx_byte)
	);

	step_core core0
	(
		.clk     (clk),
		.rst     (rst),
		.step_en (step_en),
		.snap    (snap)
	);

endmodule

// File: design/debug_unit.sv
`timescale 1ns/100ps

module debug_unit
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rx_rdy,
	input  logic [7:0]           rx_byte,
	input  logic                 tx_done,
	input  core_pkg::core_snap_t snap,
	output logic                 step_en,
	output logic                 tx_write,
	output logic [7:0]           tx_byte
);

	import link_pkg::*;

	dbg_state_e state;
	// Dump image, top byte goes out first
	logic [DUMP_BYTES-1:0][7:0] dump_q;
	// Bytes already handed to the transmitter
	logic [DUMP_CNT_W-1:0] byte_cnt;

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			step_en <= 1'b0;
			tx_write <= 1'b0;
			byte_cnt <= '0;
		end
		else
		begin
			tx_write <= 1'b0;
			case (state)
				IDLE:
				begin
					// Bytes arriving in other states are lost
					if (rx_rdy && rx_byte == CMD_STEP)
					begin
						step_en <= 1'b1;
						state <= STEP;
					end
					else if (rx_rdy && rx_byte == CMD_CONT)
					begin
						step_en <= 1'b1;
						state <= RUN;
					end
				end
				STEP:
				begin
					// Single step pulse
					step_en <= 1'b0;
					state <= LOAD;
				end
				RUN:
				begin
					// Keep stepping until the core reports HALT
					if (snap.halted[0])
					begin
						step_en <= 1'b0;
						state <= LOAD;
					end
				end
				LOAD:
				begin
					byte_cnt <= '0;
					state <= SEND;
				end
				SEND:
				begin
					// Transmitter is idle here, tx_done came first
					tx_write <= 1'b1;
					state <= WAIT_DONE;
				end
				WAIT_DONE:
				begin
					if (tx_done)
					begin
						if (byte_cnt == DUMP_LAST)
							state <= IDLE;
						else
						begin
							byte_cnt <= byte_cnt + DUMP_CNT_W'(1);
							state <= SEND;
						end
					end
				end
				default:
				begin
					step_en <= 1'b0;
					state <= IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Dump register
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == LOAD)
		begin
			// Snapshot frozen here, core may not change it mid dump anyway
			dump_q <= {
				DUMP_MAGIC,
				snap.pc,
				snap.acc,
				{6'b0, snap.instr.op},
				snap.instr.operand,
				snap.step_count[7:0],
				snap.step_count[15:8],
				snap.halted
			};
		end
		else if (state == SEND)
		begin
			tx_byte <= dump_q[DUMP_BYTES-1];
			dump_q <= {dump_q[DUMP_BYTES-2:0], 8'h00};
		end
	end

	// No stepping while loading or dumping
	a_step_scope: assert property (@(posedge clk) disable iff (rst)
		step_en |-> (state == STEP || state == RUN));

endmodule

// File: design/link_pkg.sv
package link_pkg;

	////////////////////////////////////////
	// Serial line timing
	////////////////////////////////////////

	localparam int CLKS_PER_BIT = 16;
	localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);

	// Last count of a full bit period
	localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
	// Middle of the start bit
	localparam logic [BAUD_CNT_W-1:0] BAUD_HALF = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

	////////////////////////////////////////
	// Host commands and dump format
	////////////////////////////////////////

	// 'p', step one instruction
	localparam logic [7:0] CMD_STEP = 8'h70;
	// 'c', run until HALT
	localparam logic [7:0] CMD_CONT = 8'h63;

	// Leads every dump
	localparam logic [7:0] DUMP_MAGIC = 8'hA5;

	localparam int DUMP_BYTES = 8;
	localparam int DUMP_CNT_W = $clog2(DUMP_BYTES);
	localparam logic [DUMP_CNT_W-1:0] DUMP_LAST = DUMP_CNT_W'(DUMP_BYTES - 1);

	// Debug controller states
	typedef enum logic [2:0]
	{
		IDLE,
		STEP,
		RUN,
		LOAD,
		SEND,
		WAIT_DONE
	} dbg_state_e;

endpackage

// File: design/step_core.sv
`timescale 1ns/100ps

module step_core
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 step_en,
	output core_pkg::core_snap_t snap
);

	import core_pkg::*;

	logic [7:0]  pc;
	logic [7:0]  acc;
	logic [15:0] step_count;
	logic        halted;
	// Last executed instruction
	core_instr_t ir;
	core_instr_t fetch;

	////////////////////////////////////////
	// Fetch
	////////////////////////////////////////

	// Past the end of the ROM reads as HALT
	always_comb
	begin
		fetch = '{op: HALT, operand: 8'h00};
		if (pc < 8'(PROG_LEN))
			fetch = PROG_ROM[pc[2:0]];
	end

	////////////////////////////////////////
	// Execute
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= '0;
			acc <= '0;
			step_count <= '0;
			halted <= 1'b0;
			ir <= '0;
		end
		else if (step_en && !halted)
		begin
			ir <= fetch;
			// HALT counts as an executed instruction
			step_count <= step_count + 16'd1;
			pc <= pc + 8'd1;
			case (fetch.op)
				LDI:
					acc <= fetch.operand;
				ADDI:
					acc <= acc + fetch.operand;
				XORI:
					acc <= acc ^ fetch.operand;
				HALT:
				begin
					// pc stays on the HALT
					pc <= pc;
					halted <= 1'b1;
				end
				default:
					halted <= 1'b1;
			endcase
		end
	end

	assign snap = '{
		pc:         pc,
		acc:        acc,
		instr_pad:  6'b0,
		instr:      ir,
		step_count: step_count,
		halted:     {7'b0, halted}
	};

endmodule

// File: design/uart_rx.sv
`timescale 1ns/100ps

module uart_rx
(
	input  logic       clk,
	input  logic       rst,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_rdy
);

	import link_pkg::*;

	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e             state;
	logic                  rx_meta;
	logic                  rx_sync;
	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [2:0]            bit_idx;
	logic [7:0]            shift_q;

	// Shift register holds the finished byte until the next frame
	assign rx_byte = shift_q;

	// Two flop synchronizer, line idles high
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			rx_rdy <= 1'b0;
		end
		else
		begin
			rx_rdy <= 1'b0;
			baud_cnt <= baud_cnt + BAUD_CNT_W'(1);
			case (state)
				RX_IDLE:
				begin
					baud_cnt <= '0;
					// Falling edge starts a frame
					if (!rx_sync)
						state <= RX_START;
				end
				RX_START:
				begin
					// Recheck at mid start bit, a glitch goes back to idle
					if (baud_cnt == BAUD_HALF)
					begin
						baud_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA:
				begin
					if (baud_cnt == BAUD_LAST)
					begin
						baud_cnt <= '0;
						// LSB first, shift in from the top
						shift_q <= {rx_sync, shift_q[7:1]};
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP:
				begin
					if (baud_cnt == BAUD_LAST)
					begin
						// Low stop bit drops the frame
						rx_rdy <= rx_sync;
						state <= RX_IDLE;
					end
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	a_rdy_single: assert property (@(posedge clk) disable iff (rst)
		rx_rdy |=> !rx_rdy);

endmodule

// File: design/uart_tx.sv
`timescale 1ns/100ps

module uart_tx
(
	input  logic       clk,
	input  logic       rst,
	input  logic       tx_write,
	input  logic [7:0] tx_byte,
	output logic       tx,
	output logic       tx_done
);

	import link_pkg::*;

	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	tx_state_e             state;
	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [2:0]            bit_idx;
	logic [7:0]            shift_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= TX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			tx <= 1'b1;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			baud_cnt <= baud_cnt + BAUD_CNT_W'(1);
			case (state)
				TX_IDLE:
				begin
					baud_cnt <= '0;
					if (tx_write)
					begin
						shift_q <= tx_byte;
						// Start bit
						tx <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START:
				begin
					if (baud_cnt == BAUD_LAST)
					begin
						baud_cnt <= '0;
						bit_idx <= '0;
						tx <= shift_q[0];
						state <= TX_DATA;
					end
				end
				TX_DATA:
				begin
					if (baud_cnt == BAUD_LAST)
					begin
						baud_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						shift_q <= {1'b0, shift_q[7:1]};
						tx <= shift_q[1];
						// After bit 7 the line goes to the stop level
						if (bit_idx == 3'd7)
						begin
							tx <= 1'b1;
							state <= TX_STOP;
						end
					end
				end
				TX_STOP:
				begin
					// Done fires as the line returns to idle
					if (baud_cnt == BAUD_LAST)
					begin
						tx_done <= 1'b1;
						state <= TX_IDLE;
					end
				end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

	// Writer must hold off until the frame finishes
	a_write_idle: assert property (@(posedge clk) disable iff (rst)
		tx_write |-> state == TX_IDLE);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_debug_top \
	-f compile.f --Mdir "$BUILD_DIR" -o tb_debug_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_debug_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: test/uart_bfm.svh
`ifndef UART_BFM_SVH
`define UART_BFM_SVH

// Serial line tasks, included inside the testbench module
// Uses clk, rx_line, tx_line, errors and the link timing constants

// One 8N1 frame on rx_line, LSB first
task automatic send_byte(input logic [7:0] data);
	logic [9:0] frame;
	// Stop, data, start from top to bottom
	frame = {1'b1, data, 1'b0};
	@(posedge clk);
	#DRIVE_DELAY;
	repeat (10)
	begin
		rx_line = frame[0];
		frame = frame >> 1;
		repeat (CLKS_PER_BIT) @(posedge clk);
		#DRIVE_DELAY;
	end
endtask

// Waits for a start bit on tx_line, then samples mid-bit on falling clock edges
task automatic recv_byte(output logic [7:0] data, output logic ok);
	int waited;
	waited = 0;
	data = '0;
	ok = 1'b0;
	@(negedge clk);
	while (tx_line !== 1'b0 && waited < RX_TIMEOUT_CLKS)
	begin
		@(negedge clk);
		waited++;
	end
	assert (tx_line === 1'b0)
	else
	begin
		$display("No start bit on tx within %0d bit periods", RX_TIMEOUT_CLKS / CLKS_PER_BIT);
		errors++;
	end
	if (tx_line === 1'b0)
	begin
		// Middle of the start bit
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		repeat (8)
		begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			// LSB arrives first
			data = {tx_line, data[7:1]};
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		ok = (tx_line === 1'b1);
		assert (ok)
		else
		begin
			$display("Stop bit on tx was low, frame broken");
			errors++;
		end
	end
endtask

`endif

// File: test/tb_debug_top.sv
`timescale 1ns/100ps

module tb_debug_top;

	import core_pkg::*;
	import link_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int NUM_TESTS = 5;
	// Per-byte wait covering the command frame plus latency
	localparam int RX_TIMEOUT_CLKS = 20 * CLKS_PER_BIT;
	localparam int FRAME_NS = 10 * CLKS_PER_BIT * CLK_PERIOD;
	localparam int WATCHDOG_NS = NUM_TESTS * 12 * FRAME_NS + 30 * FRAME_NS;

	logic clk;
	logic rst;
	logic rx_line;
	logic tx_line;

	int errors;
	int tests_ok;
	int tests_bad;

	// Reference core state
	logic [7:0]  m_pc;
	logic [7:0]  m_acc;
	core_op_e    m_op;
	logic [7:0]  m_operand;
	logic [15:0] m_count;
	logic        m_halted;

	debug_top dut0
	(
		.clk (clk),
		.rst (rst),
		.rx  (rx_line),
		.tx  (tx_line)
	);

	`include "uart_bfm.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	task automatic reset_model();
		m_pc = '0;
		m_acc = '0;
		m_op = LDI;
		m_operand = '0;
		m_count = '0;
		m_halted = 1'b0;
	endtask

	task automatic step_model();
		core_instr_t ins;
		// A halted core ignores steps
		if (!m_halted)
		begin
			ins = PROG_ROM[m_pc[2:0]];
			m_op = ins.op;
			m_operand = ins.operand;
			m_count = m_count + 16'd1;
			case (ins.op)
				LDI:
					m_acc = ins.operand;
				ADDI:
					m_acc = m_acc + ins.operand;
				XORI:
					m_acc = m_acc ^ ins.operand;
				default:
					m_halted = 1'b1;
			endcase
			if (!m_halted)
				m_pc = m_pc + 8'd1;
		end
	endtask

	task automatic run_model_to_halt();
		while (!m_halted)
			step_model();
	endtask

	// First byte on the wire sits on top
	function automatic logic [63:0] expected_dump();
		return {DUMP_MAGIC, m_pc, m_acc, {6'b0, m_op}, m_operand,
			m_count[7:0], m_count[15:8], 7'b0, m_halted};
	endfunction

	function automatic string field_name(input int idx);
		case (idx)
			0: return "magic";
			1: return "pc";
			2: return "acc";
			3: return "opcode";
			4: return "operand";
			5: return "step_count_lo";
			6: return "step_count_hi";
			default: return "halted";
		endcase
	endfunction

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	task automatic apply_reset();
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
	endtask

	// tx must stay high for the whole window
	task automatic check_quiet(input int bits);
		int busy;
		busy = 0;
		repeat (bits * CLKS_PER_BIT)
		begin
			@(negedge clk);
			if (tx_line !== 1'b1)
				busy++;
		end
		assert (busy == 0)
		else
		begin
			$display("Unexpected traffic on tx, line not idle for %0d clocks", busy);
			errors++;
		end
	endtask

	task automatic recv_dump(output logic [63:0] got, output logic ok);
		logic [7:0] b;
		logic byte_ok;
		got = '0;
		ok = 1'b1;
		repeat (DUMP_BYTES)
		begin
			// Stop at the first missing byte
			if (ok)
			begin
				recv_byte(b, byte_ok);
				got = {got[55:0], b};
				ok = byte_ok;
			end
		end
	endtask

	// Sends a command while listening for the dump and checks every field
	task automatic run_command(input logic [7:0] cmd);
		logic [63:0] got;
		logic [63:0] exp;
		logic ok;
		fork
			send_byte(cmd);
			recv_dump(got, ok);
		join
		exp = expected_dump();
		if (ok)
		begin
			for (int i = 0; i < DUMP_BYTES; i++)
			begin
				assert (got[63:56] == exp[63:56])
				else
				begin
					$display("ERROR %s expected %h got %h",
						field_name(i), exp[63:56], got[63:56]);
					errors++;
				end
				got = got << 8;
				exp = exp << 8;
			end
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (errors == err_before)
		begin
			tests_ok++;
			$display("%s: ok", name);
		end
		else
		begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - err_before);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic idle_after_reset();
		int e0;
		e0 = errors;
		check_quiet(20);
		finish_test("idle line after reset", e0);
	endtask

	task automatic single_step();
		int e0;
		e0 = errors;
		step_model();
		run_command(CMD_STEP);
		finish_test("single step", e0);
	endtask

	task automatic step_sequence();
		int e0;
		e0 = errors;
		repeat (3)
		begin
			step_model();
			run_command(CMD_STEP);
		end
		finish_test("step sequence", e0);
	endtask

	task automatic continue_to_halt();
		int e0;
		e0 = errors;
		run_model_to_halt();
		run_command(CMD_CONT);
		// Halted core gives the same dump again
		step_model();
		run_command(CMD_STEP);
		finish_test("continue to halt", e0);
	endtask

	task automatic ignored_bytes_then_rerun();
		int e0;
		logic [31:0] rnd;
		logic [7:0] b;
		e0 = errors;
		repeat (3)
		begin
			rnd = $urandom;
			b = rnd[7:0];
			while (b == CMD_STEP || b == CMD_CONT)
			begin
				rnd = $urandom;
				b = rnd[7:0];
			end
			send_byte(b);
			check_quiet(20);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		apply_reset();
		reset_model();
		run_model_to_halt();
		run_command(CMD_CONT);
		finish_test("ignored bytes and rerun", e0);
	endtask

	////////////////////////////////////////
	// Run control
	////////////////////////////////////////

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		rx_line = 1'b1;
		errors = 0;
		tests_ok = 0;
		tests_bad = 0;
		void'($urandom(32'h5c254d2b));
		reset_model();
		apply_reset();
		idle_after_reset();
		single_step();
		step_sequence();
		continue_to_halt();
		ignored_bytes_then_rerun();
		$display("Tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
